// ==== src/exu_cfg.svh ====
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath and address width
`define EXU_XLEN 32

// rv32e has 16 architectural registers
`define EXU_RA_W 4

`define EXU_BYPASS_DEPTH 4

`endif

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // lui just forwards the immediate
        alu_pass_b = 4'd10
    } alu_fn_e;

    typedef enum logic [2:0] {
        br_eq  = 3'd0,
        br_ne  = 3'd1,
        br_lt  = 3'd2,
        br_ge  = 3'd3,
        br_ltu = 3'd4,
        br_geu = 3'd5
    } br_cond_e;

    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_branch = 2'd1,
        kind_jump   = 2'd2
    } exu_kind_e;

    // alu view for kind_alu, branch view for kind_branch and kind_jump
    typedef union packed {
        alu_fn_e alu;
        struct packed {
            logic     jalr;
            br_cond_e cond;
        } br;
    } exu_ctrl_u;

endpackage

// ==== src/exu_pipe_pkg.sv ====
package exu_pipe_pkg;

    typedef enum logic [2:0] {
        mem_none = 3'd0,
        mem_lw   = 3'd1,
        mem_lh   = 3'd2,
        mem_lb   = 3'd3,
        mem_sw   = 3'd4,
        mem_sh   = 3'd5,
        mem_sb   = 3'd6
    } mem_op_e;

    // loads return their data later through load_done
    function automatic logic mem_is_load(mem_op_e op);
        return op inside {mem_lw, mem_lh, mem_lb};
    endfunction

endpackage

// ==== src/exu_bypass.sv ====
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_bypass (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`EXU_RA_W-1:0] rs1,
    input  logic [`EXU_RA_W-1:0] rs2,
    input  logic [`EXU_XLEN-1:0] rf_src1,
    input  logic [`EXU_XLEN-1:0] rf_src2,
    input  logic                 hist_we,
    input  logic [`EXU_RA_W-1:0] hist_rd,
    input  logic [`EXU_XLEN-1:0] hist_data,
    input  logic                 hist_is_load,
    input  logic                 load_done,
    input  logic [`EXU_XLEN-1:0] load_data,
    output logic [`EXU_XLEN-1:0] src1,
    output logic [`EXU_XLEN-1:0] src2,
    output logic                 load_wait
);
    localparam int DEPTH = `EXU_BYPASS_DEPTH;

    // entry 0 is the newest write
    logic [DEPTH-1:0][`EXU_RA_W-1:0] ent_rd;
    logic [DEPTH-1:0][`EXU_XLEN-1:0] ent_data;
    logic [DEPTH-1:0]                ent_valid;
    logic [DEPTH-1:0]                ent_pending;

    logic [1:0][`EXU_RA_W-1:0] rs;
    logic [1:0][`EXU_XLEN-1:0] rf_val;
    logic [1:0][`EXU_XLEN-1:0] sel_val;
    logic [1:0]                src_wait;

    assign rs[0]     = rs1;
    assign rs[1]     = rs2;
    assign rf_val[0] = rf_src1;
    assign rf_val[1] = rf_src2;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            sel_val[s]  = rf_val[s];
            src_wait[s] = 1'b0;
            // walk oldest to newest so the newest match is kept
            for (int i = DEPTH - 1; i >= 0; i--) begin
                if (ent_valid[i] && ent_rd[i] == rs[s] && rs[s] != '0) begin
                    if (ent_pending[i]) begin
                        // load data arriving this cycle can be used directly
                        sel_val[s]  = load_data;
                        src_wait[s] = !load_done;
                    end else begin
                        sel_val[s]  = ent_data[i];
                        src_wait[s] = 1'b0;
                    end
                end
            end
        end
    end

    assign src1      = sel_val[0];
    assign src2      = sel_val[1];
    assign load_wait = |src_wait;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid   <= '0;
            ent_pending <= '0;
        end else if (hist_we) begin
            ent_valid   <= {ent_valid[DEPTH-2:0], 1'b1};
            ent_pending <= {ent_pending[DEPTH-2:0] & ~{(DEPTH-1){load_done}}, hist_is_load};
        end else if (load_done) begin
            ent_pending <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (hist_we) begin
            ent_rd[0]   <= hist_rd;
            ent_data[0] <= hist_data;
            for (int i = 1; i < DEPTH; i++) begin
                ent_rd[i]   <= ent_rd[i-1];
                ent_data[i] <= (load_done && ent_pending[i-1]) ? load_data : ent_data[i-1];
            end
        end else if (load_done) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (ent_pending[i]) begin
                    ent_data[i] <= load_data;
                end
            end
        end
    end

endmodule

// ==== src/exu_alu.sv ====
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_alu
    import rv_isa_pkg::*;
(
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] src1,
    input  logic [`EXU_XLEN-1:0] src2,
    input  logic [`EXU_XLEN-1:0] imm,
    input  exu_kind_e            kind,
    input  exu_ctrl_u            ctrl,
    input  logic                 src1_is_pc,
    input  logic                 src2_is_imm,
    output logic [`EXU_XLEN-1:0] result,
    output logic                 taken,
    output logic [`EXU_XLEN-1:0] target
);
    localparam int SHW = $clog2(`EXU_XLEN);
    localparam logic [`EXU_XLEN-1:0] insn_bytes = 4;

    logic [`EXU_XLEN-1:0] op_a;
    logic [`EXU_XLEN-1:0] op_b;
    logic [`EXU_XLEN-1:0] alu_out;
    logic [`EXU_XLEN-1:0] jalr_sum;
    logic [SHW-1:0]       shamt;
    logic                 br_hit;

    assign op_a     = src1_is_pc ? pc : src1;
    assign op_b     = src2_is_imm ? imm : src2;
    assign shamt    = op_b[SHW-1:0];
    assign jalr_sum = src1 + imm;

    always_comb begin
        alu_out = '0;
        case (ctrl.alu)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_slt:    alu_out[0] = $signed(op_a) < $signed(op_b);
            alu_sltu:   alu_out[0] = op_a < op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $unsigned($signed(op_a) >>> shamt);
            alu_or:     alu_out = op_a | op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // compare always uses the register operands
    always_comb begin
        case (ctrl.br.cond)
            br_eq:   br_hit = src1 == src2;
            br_ne:   br_hit = src1 != src2;
            br_lt:   br_hit = $signed(src1) < $signed(src2);
            br_ge:   br_hit = $signed(src1) >= $signed(src2);
            br_ltu:  br_hit = src1 < src2;
            br_geu:  br_hit = src1 >= src2;
            default: br_hit = 1'b0;
        endcase
    end

    always_comb begin
        result = '0;
        taken  = 1'b0;
        target = pc + imm;
        case (kind)
            kind_alu:    result = alu_out;
            kind_branch: taken = br_hit;
            kind_jump: begin
                // link address
                result = pc + insn_bytes;
                taken  = 1'b1;
                if (ctrl.br.jalr) begin
                    target = {jalr_sum[`EXU_XLEN-1:1], 1'b0};
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== src/exu_out_reg.sv ====
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_out_reg
    import exu_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic                 lsu_ready,
    input  logic                 load_wait,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_RA_W-1:0] rd,
    input  logic                 gpr_we,
    input  mem_op_e              mem_op,
    input  logic [`EXU_XLEN-1:0] result,
    input  logic [`EXU_XLEN-1:0] src2,
    input  logic                 taken,
    input  logic [`EXU_XLEN-1:0] target,
    input  logic                 redirect_ack,
    output logic                 in_ready,
    output logic                 hist_we,
    output logic [`EXU_RA_W-1:0] hist_rd,
    output logic [`EXU_XLEN-1:0] hist_data,
    output logic                 hist_is_load,
    output logic                 out_valid,
    output logic [`EXU_XLEN-1:0] out_pc,
    output logic [`EXU_RA_W-1:0] out_rd,
    output logic                 out_gpr_we,
    output mem_op_e              out_mem_op,
    output logic [`EXU_XLEN-1:0] out_result,
    output logic [`EXU_XLEN-1:0] out_store_data,
    output logic                 redirect_valid,
    output logic [`EXU_XLEN-1:0] redirect_pc
);
    localparam logic [`EXU_XLEN-1:0] insn_bytes = 4;

    logic accept;
    logic live;
    logic is_load;
    logic redir_set;

    // wrong-path instructions drain even if their operands are not ready
    assign in_ready  = lsu_ready && (redirect_valid || !load_wait);
    assign accept    = in_valid && in_ready;
    assign live      = accept && !redirect_valid;
    assign is_load   = mem_is_load(mem_op);
    assign redir_set = live && taken && (target != pc + insn_bytes);

    assign hist_we      = live && gpr_we;
    assign hist_rd      = rd;
    assign hist_is_load = is_load;
    // load value is filled in later when load_done arrives
    assign hist_data    = is_load ? '0 : result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (lsu_ready) begin
            out_valid <= live;
        end
    end

    always_ff @(posedge clk) begin
        if (live) begin
            out_pc         <= pc;
            out_rd         <= rd;
            out_gpr_we     <= gpr_we;
            out_mem_op     <= mem_op;
            out_result     <= result;
            out_store_data <= src2;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else if (redirect_valid) begin
            if (redirect_ack) begin
                redirect_valid <= 1'b0;
            end
        end else if (redir_set) begin
            redirect_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redir_set) begin
            redirect_pc <= target;
        end
    end

endmodule

// ==== src/exu_top.sv ====
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_top
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [`EXU_XLEN-1:0] in_pc,
    input  logic [`EXU_RA_W-1:0] in_rs1,
    input  logic [`EXU_RA_W-1:0] in_rs2,
    input  logic [`EXU_RA_W-1:0] in_rd,
    input  logic [`EXU_XLEN-1:0] in_rf_src1,
    input  logic [`EXU_XLEN-1:0] in_rf_src2,
    input  logic [`EXU_XLEN-1:0] in_imm,
    input  exu_kind_e            in_kind,
    input  exu_ctrl_u            in_ctrl,
    input  logic                 in_src1_is_pc,
    input  logic                 in_src2_is_imm,
    input  logic                 in_gpr_we,
    input  mem_op_e              in_mem_op,
    output logic                 out_valid,
    output logic [`EXU_XLEN-1:0] out_pc,
    output logic [`EXU_RA_W-1:0] out_rd,
    output logic                 out_gpr_we,
    output mem_op_e              out_mem_op,
    output logic [`EXU_XLEN-1:0] out_result,
    output logic [`EXU_XLEN-1:0] out_store_data,
    input  logic                 lsu_ready,
    input  logic                 load_done,
    input  logic [`EXU_XLEN-1:0] load_data,
    output logic                 redirect_valid,
    output logic [`EXU_XLEN-1:0] redirect_pc,
    input  logic                 redirect_ack
);
    logic [`EXU_XLEN-1:0] src1;
    logic [`EXU_XLEN-1:0] src2;
    logic                 load_wait;
    logic [`EXU_XLEN-1:0] result;
    logic                 taken;
    logic [`EXU_XLEN-1:0] target;
    logic                 hist_we;
    logic [`EXU_RA_W-1:0] hist_rd;
    logic [`EXU_XLEN-1:0] hist_data;
    logic                 hist_is_load;

    exu_bypass u_bypass (
        .clk          (clk),
        .rst          (rst),
        .rs1          (in_rs1),
        .rs2          (in_rs2),
        .rf_src1      (in_rf_src1),
        .rf_src2      (in_rf_src2),
        .hist_we      (hist_we),
        .hist_rd      (hist_rd),
        .hist_data    (hist_data),
        .hist_is_load (hist_is_load),
        .load_done    (load_done),
        .load_data    (load_data),
        .src1         (src1),
        .src2         (src2),
        .load_wait    (load_wait)
    );

    exu_alu u_alu (
        .pc          (in_pc),
        .src1        (src1),
        .src2        (src2),
        .imm         (in_imm),
        .kind        (in_kind),
        .ctrl        (in_ctrl),
        .src1_is_pc  (in_src1_is_pc),
        .src2_is_imm (in_src2_is_imm),
        .result      (result),
        .taken       (taken),
        .target      (target)
    );

    exu_out_reg u_out_reg (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .lsu_ready      (lsu_ready),
        .load_wait      (load_wait),
        .pc             (in_pc),
        .rd             (in_rd),
        .gpr_we         (in_gpr_we),
        .mem_op         (in_mem_op),
        .result         (result),
        .src2           (src2),
        .taken          (taken),
        .target         (target),
        .redirect_ack   (redirect_ack),
        .in_ready       (in_ready),
        .hist_we        (hist_we),
        .hist_rd        (hist_rd),
        .hist_data      (hist_data),
        .hist_is_load   (hist_is_load),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_rd         (out_rd),
        .out_gpr_we     (out_gpr_we),
        .out_mem_op     (out_mem_op),
        .out_result     (out_result),
        .out_store_data (out_store_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== test/exu_assert.sv ====
`timescale 1ns/1ps

module exu_assert (
    input logic clk,
    input logic rst,
    input logic out_valid,
    input logic redirect_valid,
    input logic redirect_ack,
    input logic hist_we
);

    // output register is cleared by reset
    assert property (@(posedge clk) rst |-> !out_valid)
        else $error("out_valid high during reset");

    // redirect is held until fetch acknowledges it
    assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !redirect_ack |=> redirect_valid)
        else $error("redirect_valid dropped without redirect_ack");

    // wrong-path instructions must not reach the bypass history
    assert property (@(posedge clk) disable iff (rst) redirect_valid |-> !hist_we)
        else $error("history write while a redirect is held");

endmodule

bind exu_top exu_assert u_assert (
    .clk            (clk),
    .rst            (rst),
    .out_valid      (out_valid),
    .redirect_valid (redirect_valid),
    .redirect_ack   (redirect_ack),
    .hist_we        (hist_we)
);

// ==== test/exu_tb.sv ====
`timescale 1ns/1ps
`include "exu_cfg.svh"

module exu_tb
    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;
();
    localparam int DEPTH   = `EXU_BYPASS_DEPTH;
    localparam int N_ALU   = 200;
    localparam int N_CHAIN = 24;
    localparam int N_LOAD  = 16;
    localparam int N_REDIR = 12;
    localparam int N_STALL = 160;
    localparam int N_ISSUE = N_ALU + N_CHAIN + 2 * N_LOAD + 4 * N_REDIR + 2 * N_STALL;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rd;
        logic        gpr_we;
        mem_op_e     mem_op;
        logic [31:0] result;
        logic [31:0] store_data;
    } rec_t;

    logic        clk, rst, in_valid, in_ready, in_src1_is_pc, in_src2_is_imm, in_gpr_we;
    logic [31:0] in_pc, in_rf_src1, in_rf_src2, in_imm;
    logic [3:0]  in_rs1, in_rs2, in_rd, in_ctrl;
    exu_kind_e   in_kind;
    mem_op_e     in_mem_op;
    logic        out_valid, out_gpr_we, lsu_ready, load_done, redirect_valid, redirect_ack;
    logic [31:0] out_pc, out_result, out_store_data, load_data, redirect_pc;
    logic [3:0]  out_rd;
    mem_op_e     out_mem_op;

    rec_t        exp_q[$];
    logic [31:0] regs[16];
    logic [31:0] lag[16];
    logic [3:0]  wq_rd[$];
    logic [31:0] wq_data[$];
    logic [31:0] pc_cnt, ld_val;
    bit          stall_mode, ld_pending, expect_load_wait, redir_held;
    int          ld_delay;

    exu_top u_exu_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // expected behavior straight from the rv32 rules
    function automatic void ref_exec(input exu_kind_e kind, input logic [3:0] ctrl,
                                     input logic [31:0] pc, input logic [31:0] a,
                                     input logic [31:0] b, input logic [31:0] imm,
                                     input logic s1pc, input logic s2imm,
                                     output logic [31:0] res, output logic tk,
                                     output logic [31:0] tgt);
        logic [31:0] x;
        logic [31:0] y;
        logic [4:0]  sh;
        logic        lt_s;
        logic        lt_xy;
        x     = s1pc ? pc : a;
        y     = s2imm ? imm : b;
        sh    = y[4:0];
        lt_s  = (a[31] != b[31]) ? a[31] : (a < b);
        lt_xy = (x[31] != y[31]) ? x[31] : (x < y);
        res   = 32'h0;
        tk    = 1'b0;
        tgt   = pc + imm;
        if (kind == kind_alu) begin
            case (ctrl)
                4'd0: res = x + y;
                4'd1: res = x - y;
                4'd2: res = x << sh;
                4'd3: res = {31'b0, lt_xy};
                4'd4: res = {31'b0, x < y};
                4'd5: res = x ^ y;
                4'd6: res = x >> sh;
                4'd7: res = (x >> sh) | (x[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                4'd8: res = x | y;
                4'd9: res = x & y;
                4'd10: res = y;
                default: res = 32'h0;
            endcase
        end else if (kind == kind_branch) begin
            case (ctrl[2:0])
                3'd0: tk = (a == b);
                3'd1: tk = (a != b);
                3'd2: tk = lt_s;
                3'd3: tk = !lt_s;
                3'd4: tk = (a < b);
                3'd5: tk = !(a < b);
                default: tk = 1'b0;
            endcase
        end else begin
            res = pc + 32'd4;
            tk  = 1'b1;
            if (ctrl[3]) begin
                tgt = (a + imm) & ~32'd1;
            end
        end
    endfunction

    // lagged copy only learns a write once it has left the bypass history
    task automatic record_write(input logic [3:0] rd, input logic [31:0] val);
        if (rd != 4'd0) begin
            regs[rd] = val;
        end
        wq_rd.push_back(rd);
        wq_data.push_back(val);
        while (wq_rd.size() > DEPTH) begin
            if (wq_rd[0] != 4'd0) begin
                lag[wq_rd[0]] = wq_data[0];
            end
            void'(wq_rd.pop_front());
            void'(wq_data.pop_front());
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        if (load_done) begin
            load_done = 1'b0;
        end else if (ld_pending) begin
            if (ld_delay == 0) begin
                load_done  = 1'b1;
                load_data  = ld_val;
                ld_pending = 1'b0;
            end else begin
                ld_delay--;
            end
        end
        lsu_ready    = stall_mode ? ($urandom_range(3, 0) != 0) : 1'b1;
        redirect_ack = 1'b0;
    endtask

    task automatic issue(input exu_kind_e kind, input logic [3:0] ctrl, input logic [3:0] rs1,
                         input logic [3:0] rs2, input logic [3:0] rd, input logic [31:0] imm,
                         input logic s1pc, input logic s2imm, input logic we,
                         input mem_op_e mop);
        logic [31:0] a, b, res, tgt;
        logic        tk, live, is_ld;
        rec_t        r;
        in_rf_src1 = (rs1 == 4'd0) ? $urandom : lag[rs1];
        in_rf_src2 = (rs2 == 4'd0) ? $urandom : lag[rs2];
        a = (rs1 == 4'd0) ? in_rf_src1 : regs[rs1];
        b = (rs2 == 4'd0) ? in_rf_src2 : regs[rs2];
        in_kind        = kind;
        in_ctrl        = ctrl;
        in_rs1         = rs1;
        in_rs2         = rs2;
        in_rd          = rd;
        in_imm         = imm;
        in_src1_is_pc  = s1pc;
        in_src2_is_imm = s2imm;
        in_gpr_we      = we;
        in_mem_op      = mop;
        in_pc          = pc_cnt;
        in_valid       = 1'b1;
        is_ld          = (mop == mem_lw);
        while (1) begin
            @(posedge clk);
            if (in_ready) break;
            next_cycle();
        end
        live = !redir_held;
        ref_exec(kind, ctrl, pc_cnt, a, b, imm, s1pc, s2imm, res, tk, tgt);
        if (live) begin
            if (expect_load_wait && ld_pending) begin
                abort("dependent instruction accepted before its load returned");
            end
            r = '{pc: pc_cnt, rd: rd, gpr_we: we, mem_op: mop, result: res, store_data: b};
            exp_q.push_back(r);
            if (is_ld) begin
                ld_val     = $urandom;
                ld_delay   = int'($urandom_range(3, 0));
                ld_pending = 1'b1;
            end
            if (we) begin
                record_write(rd, is_ld ? ld_val : res);
            end
        end
        next_cycle();
        in_valid = 1'b0;
        if (live && kind != kind_alu) begin
            if (tk && tgt != pc_cnt + 32'd4) begin
                check("redirect_valid", 32'(redirect_valid), 32'd1);
                check("redirect_pc", redirect_pc, tgt);
                redir_held = 1'b1;
            end else begin
                check("redirect_valid", 32'(redirect_valid), 32'd0);
            end
        end
        pc_cnt = pc_cnt + 32'd4;
    endtask

    task automatic rand_alu();
        logic [3:0] fn;
        fn = 4'($urandom_range(10, 0));
        issue(kind_alu, fn, 4'($urandom), 4'($urandom), 4'($urandom), $urandom,
              (fn == 4'd0) && ($urandom_range(7, 0) == 0), 1'($urandom), 1'b1, mem_none);
    endtask

    task automatic load_pair();
        logic [3:0] rd;
        while (ld_pending) next_cycle();
        rd = 4'($urandom_range(15, 1));
        issue(kind_alu, 4'd0, 4'($urandom), 4'd0, rd, 32'($urandom_range(255, 0)),
              1'b0, 1'b1, 1'b1, mem_lw);
        expect_load_wait = 1'b1;
        issue(kind_alu, 4'd0, rd, 4'($urandom), 4'($urandom), 32'h0, 1'b0, 1'b0, 1'b1,
              mem_none);
        expect_load_wait = 1'b0;
    endtask

    // compares each record the load/store stage takes
    initial begin
        rec_t r;
        forever begin
            @(posedge clk);
            if (!rst && out_valid && lsu_ready) begin
                if (exp_q.size() == 0) begin
                    abort("record appeared on the output with none expected");
                end else begin
                    r = exp_q.pop_front();
                    check("out_pc", out_pc, r.pc);
                    check("out_rd", 32'(out_rd), 32'(r.rd));
                    check("out_gpr_we", 32'(out_gpr_we), 32'(r.gpr_we));
                    check("out_mem_op", 32'(out_mem_op), 32'(r.mem_op));
                    check("out_result", out_result, r.result);
                    check("out_store_data", out_store_data, r.store_data);
                end
            end
        end
    end

    initial begin
        repeat (N_ISSUE * 20 + 40) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        logic [3:0] prev_rd, rd;
        logic       jalr;
        void'($urandom(20));
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_src1_is_pc  = 1'b0;
        in_src2_is_imm = 1'b0;
        in_gpr_we      = 1'b0;
        in_pc          = 32'h0;
        in_rf_src1     = 32'h0;
        in_rf_src2     = 32'h0;
        in_imm         = 32'h0;
        in_rs1         = 4'd0;
        in_rs2         = 4'd0;
        in_rd          = 4'd0;
        in_ctrl        = 4'd0;
        in_kind        = kind_alu;
        in_mem_op      = mem_none;
        lsu_ready      = 1'b1;
        load_done      = 1'b0;
        redirect_ack   = 1'b0;
        load_data      = 32'h0;
        for (int i = 0; i < 16; i++) begin
            regs[i] = 32'h0;
            lag[i]  = 32'h0;
        end
        stall_mode       = 1'b0;
        ld_pending       = 1'b0;
        expect_load_wait = 1'b0;
        redir_held       = 1'b0;
        pc_cnt = 32'h1000;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (N_ALU) rand_alu();
        // dependent chain where every fourth write targets x0
        prev_rd = 4'd1;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = (i % 4 == 3) ? 4'd0 : 4'(i % 5 + 1);
            issue(kind_alu, 4'($urandom_range(9, 0)), prev_rd, 4'($urandom_range(5, 0)), rd,
                  $urandom, 1'b0, 1'b0, 1'b1, mem_none);
            prev_rd = rd;
        end
        repeat (N_LOAD) load_pair();
        for (int i = 0; i < N_REDIR; i++) begin
            jalr = 1'($urandom);
            if (i % 2 == 0) begin
                issue(kind_branch, {1'b0, 3'($urandom_range(5, 0))}, 4'($urandom),
                      4'($urandom), 4'd0, 32'($urandom_range(15, 2)) << 2, 1'b0, 1'b0,
                      1'b0, mem_none);
            end else begin
                issue(kind_jump, {jalr, 3'b0}, 4'($urandom), 4'd0, 4'($urandom),
                      32'($urandom_range(63, 2)) << 2, 1'b0, 1'b1, 1'b1, mem_none);
            end
            repeat (3) rand_alu();
            redirect_ack = 1'b1;
            next_cycle();
            redir_held = 1'b0;
        end
        stall_mode = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            case ($urandom_range(3, 0))
                0: load_pair();
                1: issue(kind_alu, 4'd0, 4'($urandom), 4'($urandom), 4'd0,
                         32'($urandom_range(255, 0)), 1'b0, 1'b1, 1'b0, mem_sw);
                default: rand_alu();
            endcase
        end
        stall_mode = 1'b0;
        while (exp_q.size() != 0) next_cycle();
        repeat (4) next_cycle();
        if (exp_q.size() == 0 && !redirect_valid) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("records or a redirect were left over at the end");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// ==== sim.f ====
+incdir+src
src/rv_isa_pkg.sv
src/exu_pipe_pkg.sv
src/exu_bypass.sv
src/exu_alu.sv
src/exu_out_reg.sv
src/exu_top.sv
test/exu_assert.sv
test/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exu_tb -f sim.f -o exu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/exu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
